//--- verilog/cam_pkg.sv
// camera tracking package with frame geometry, colour thresholds and control enums
package cam_pkg;

  // horizontal line segments in clocks
  localparam int H_ACTIVE = 24;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical segments in lines
  localparam int V_ACTIVE = 6;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // column counter also spans the blanking part of the line
  localparam int X_WIDTH  = 5;
  localparam int Y_WIDTH  = 4;
  localparam int REGION_W = H_ACTIVE / 3;

  typedef logic [X_WIDTH-1:0] col_t;
  typedef logic [Y_WIDTH-1:0] row_t;

  // orange window on 8-bit rgb
  localparam logic [7:0] R_MIN = 8'd192;
  localparam logic [7:0] G_MIN = 8'd64;
  localparam logic [7:0] G_MAX = 8'd160;
  // blue is exclusive
  localparam logic [7:0] B_MAX = 8'd64;

  // marker shown on the monitor in place of orange
  localparam logic [7:0] MARK_R = 8'd0;
  localparam logic [7:0] MARK_G = 8'd255;
  localparam logic [7:0] MARK_B = 8'd0;

  // per-region hit counter width and detection limit on the sum
  localparam int HIT_W = 6;
  localparam logic [HIT_W+1:0] MIN_HITS = 8'd4;

  typedef enum logic [1:0] {DIR_LEFT, DIR_CENTER, DIR_RIGHT} dir_t;

  typedef enum logic [7:0] {
    CMD_STOP  = 8'h10,
    CMD_FWD   = 8'h11,
    CMD_LEFT  = 8'h12,
    CMD_RIGHT = 8'h13,
    CMD_AUTO  = 8'h20
  } ir_cmd_t;

  typedef enum logic [1:0] {ST_IDLE, ST_MANUAL, ST_SEARCH, ST_TRACK} drive_state_t;

  typedef enum logic [1:0] {MOT_HALT, MOT_FORWARD, MOT_TURN_LEFT, MOT_TURN_RIGHT} motion_t;

endpackage

//--- verilog/vga_timing.sv
// scan timing generator with active strobe, pixel column, syncs, blank and frame end
`timescale 1ns/1ps

module vga_timing (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic                        pix_active,
  output logic [cam_pkg::X_WIDTH-1:0] pix_x,
  output logic                        frame_end,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        blank_n
);

  cam_pkg::col_t h_cnt;
  cam_pkg::row_t v_cnt;
  logic          line_end;
  logic          frame_last;
  logic          h_sync_win;
  logic          v_sync_win;

  // last column of a line and last line of a frame
  assign line_end   = (h_cnt == cam_pkg::col_t'(cam_pkg::H_TOTAL - 1));
  assign frame_last = (v_cnt == cam_pkg::row_t'(cam_pkg::V_TOTAL - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      // line counter only moves at the end of a line
      if (frame_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // visible area sits at the start of both counters
  assign pix_active = (h_cnt < cam_pkg::col_t'(cam_pkg::H_ACTIVE)) &&
                      (v_cnt < cam_pkg::row_t'(cam_pkg::V_ACTIVE));
  assign pix_x      = h_cnt;

  // sync windows follow the front porch
  assign h_sync_win = (h_cnt >= cam_pkg::col_t'(cam_pkg::H_ACTIVE + cam_pkg::H_FRONT)) &&
                      (h_cnt <  cam_pkg::col_t'(cam_pkg::H_ACTIVE + cam_pkg::H_FRONT +
                                                cam_pkg::H_SYNC));
  assign v_sync_win = (v_cnt >= cam_pkg::row_t'(cam_pkg::V_ACTIVE + cam_pkg::V_FRONT)) &&
                      (v_cnt <  cam_pkg::row_t'(cam_pkg::V_ACTIVE + cam_pkg::V_FRONT +
                                                cam_pkg::V_SYNC));

  // frame boundary at column 0 of the first vsync line
  assign frame_end = (v_cnt == cam_pkg::row_t'(cam_pkg::V_ACTIVE + cam_pkg::V_FRONT)) &&
                     (h_cnt == '0);

  // board levels delayed one clock to line up with the finder output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      blank_n <= 1'b0;
    end else begin
      hsync   <= ~h_sync_win;
      vsync   <= ~v_sync_win;
      blank_n <= pix_active;
    end
  end

endmodule

//--- verilog/target_finder.sv
// orange pixel detector that recolours hits with the marker for the monitor
`timescale 1ns/1ps

module target_finder (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pix_active,
  input  logic [7:0] pix_r,
  input  logic [7:0] pix_g,
  input  logic [7:0] pix_b,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic       hit
);

  logic is_orange;

  // strong red, medium green, little blue
  assign is_orange = (pix_r >= cam_pkg::R_MIN) &&
                     (pix_g >= cam_pkg::G_MIN) &&
                     (pix_g <= cam_pkg::G_MAX) &&
                     (pix_b <  cam_pkg::B_MAX);

  // outputs trail the sampled pixel by one clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
      hit   <= 1'b0;
    end else if (!pix_active) begin
      // black while blanked
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
      hit   <= 1'b0;
    end else if (is_orange) begin
      vga_r <= cam_pkg::MARK_R;
      vga_g <= cam_pkg::MARK_G;
      vga_b <= cam_pkg::MARK_B;
      hit   <= 1'b1;
    end else begin
      // pass the camera colour through
      vga_r <= pix_r;
      vga_g <= pix_g;
      vga_b <= pix_b;
      hit   <= 1'b0;
    end
  end

endmodule

//--- verilog/target_classifier.sv
// per-frame hit counting over three column regions giving direction and detection
`timescale 1ns/1ps

module target_classifier (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        pix_active,
  input  logic [cam_pkg::X_WIDTH-1:0] pix_x,
  input  logic                        hit,
  input  logic                        frame_end,
  output cam_pkg::dir_t               direction,
  output logic                        detected,
  output logic                        frame_done
);

  logic                        pix_active_d;
  cam_pkg::col_t               pix_x_d;
  logic [cam_pkg::HIT_W-1:0]   cnt_l;
  logic [cam_pkg::HIT_W-1:0]   cnt_c;
  logic [cam_pkg::HIT_W-1:0]   cnt_r;
  logic [cam_pkg::HIT_W+1:0]   hit_sum;
  cam_pkg::dir_t               region;
  cam_pkg::dir_t               best_dir;
  logic                        count_en;

  // add one unless already at full scale
  function automatic logic [cam_pkg::HIT_W-1:0] sat_inc(input logic [cam_pkg::HIT_W-1:0] v);
    return (v == '1) ? v : v + 1'b1;
  endfunction

  // align column and strobe with the registered hit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_active_d <= 1'b0;
      pix_x_d      <= '0;
    end else begin
      pix_active_d <= pix_active;
      pix_x_d      <= pix_x;
    end
  end

  // split the line into thirds
  always_comb begin
    if (pix_x_d < cam_pkg::col_t'(cam_pkg::REGION_W)) begin
      region = cam_pkg::DIR_LEFT;
    end else if (pix_x_d < cam_pkg::col_t'(2 * cam_pkg::REGION_W)) begin
      region = cam_pkg::DIR_CENTER;
    end else begin
      region = cam_pkg::DIR_RIGHT;
    end
  end

  assign count_en = pix_active_d && hit;

  // largest region wins, centre beats left on a tie, left beats right
  always_comb begin
    if ((cnt_c >= cnt_l) && (cnt_c >= cnt_r)) begin
      best_dir = cam_pkg::DIR_CENTER;
    end else if (cnt_l >= cnt_r) begin
      best_dir = cam_pkg::DIR_LEFT;
    end else begin
      best_dir = cam_pkg::DIR_RIGHT;
    end
  end

  assign hit_sum = {2'b00, cnt_l} + {2'b00, cnt_c} + {2'b00, cnt_r};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_l      <= '0;
      cnt_c      <= '0;
      cnt_r      <= '0;
      direction  <= cam_pkg::DIR_CENTER;
      detected   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= frame_end;
      if (frame_end) begin
        // publish the frame result and start over
        detected <= (hit_sum >= cam_pkg::MIN_HITS);
        if (hit_sum >= cam_pkg::MIN_HITS) begin
          direction <= best_dir;
        end
        cnt_l <= '0;
        cnt_c <= '0;
        cnt_r <= '0;
      end else if (count_en) begin
        case (region)
          cam_pkg::DIR_LEFT:   cnt_l <= sat_inc(cnt_l);
          cam_pkg::DIR_CENTER: cnt_c <= sat_inc(cnt_c);
          default:             cnt_r <= sat_inc(cnt_r);
        endcase
      end
    end
  end

endmodule

//--- verilog/drive_fsm.sv
// drive controller merging remote commands, camera result and speed into a motion
`timescale 1ns/1ps

module drive_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [7:0]       ir_code,
  input  logic             ir_valid,
  input  logic [1:0]       speed,
  input  cam_pkg::dir_t    direction,
  input  logic             detected,
  input  logic             frame_done,
  output cam_pkg::motion_t motion,
  output logic [1:0]       motor_speed
);

  cam_pkg::drive_state_t state;
  cam_pkg::drive_state_t state_nxt;
  cam_pkg::motion_t      motion_nxt;
  cam_pkg::motion_t      steer;

  // camera direction as a motion
  always_comb begin
    case (direction)
      cam_pkg::DIR_LEFT:  steer = cam_pkg::MOT_TURN_LEFT;
      cam_pkg::DIR_RIGHT: steer = cam_pkg::MOT_TURN_RIGHT;
      default:            steer = cam_pkg::MOT_FORWARD;
    endcase
  end

  always_comb begin
    state_nxt  = state;
    motion_nxt = motion;
    if (ir_valid) begin
      // remote wins over a frame result in the same clock
      case (ir_code)
        cam_pkg::CMD_STOP: begin
          state_nxt  = cam_pkg::ST_IDLE;
          motion_nxt = cam_pkg::MOT_HALT;
        end
        cam_pkg::CMD_FWD: begin
          state_nxt  = cam_pkg::ST_MANUAL;
          motion_nxt = cam_pkg::MOT_FORWARD;
        end
        cam_pkg::CMD_LEFT: begin
          state_nxt  = cam_pkg::ST_MANUAL;
          motion_nxt = cam_pkg::MOT_TURN_LEFT;
        end
        cam_pkg::CMD_RIGHT: begin
          state_nxt  = cam_pkg::ST_MANUAL;
          motion_nxt = cam_pkg::MOT_TURN_RIGHT;
        end
        cam_pkg::CMD_AUTO: begin
          // spin right until something orange shows up
          state_nxt  = cam_pkg::ST_SEARCH;
          motion_nxt = cam_pkg::MOT_TURN_RIGHT;
        end
        default: begin
          // unknown buttons are ignored
        end
      endcase
    end else if (frame_done) begin
      case (state)
        cam_pkg::ST_SEARCH: begin
          if (detected) begin
            state_nxt = cam_pkg::ST_TRACK;
          end
        end
        cam_pkg::ST_TRACK: begin
          if (detected) begin
            motion_nxt = steer;
          end else begin
            // target lost, back to searching
            state_nxt  = cam_pkg::ST_SEARCH;
            motion_nxt = cam_pkg::MOT_TURN_RIGHT;
          end
        end
        default: begin
          // idle and manual ignore the camera
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= cam_pkg::ST_IDLE;
      motion      <= cam_pkg::MOT_HALT;
      motor_speed <= 2'b00;
    end else begin
      state       <= state_nxt;
      motion      <= motion_nxt;
      // speed level only reaches the motors while moving
      motor_speed <= (motion_nxt == cam_pkg::MOT_HALT) ? 2'b00 : speed;
    end
  end

endmodule

//--- verilog/cam_tracker_top.sv
// camera tracking top joining scan timing, orange finder, classifier and drive control
`timescale 1ns/1ps

module cam_tracker_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [7:0]       pix_r,
  input  logic [7:0]       pix_g,
  input  logic [7:0]       pix_b,
  input  logic [7:0]       ir_code,
  input  logic             ir_valid,
  input  logic [1:0]       speed,
  output logic             pix_active,
  output logic [7:0]       vga_r,
  output logic [7:0]       vga_g,
  output logic [7:0]       vga_b,
  output logic             hsync,
  output logic             vsync,
  output logic             blank_n,
  output cam_pkg::dir_t    direction,
  output logic             detected,
  output logic             frame_done,
  output cam_pkg::motion_t motion,
  output logic [1:0]       motor_speed
);

  logic [cam_pkg::X_WIDTH-1:0] pix_x;
  logic                        frame_end;
  logic                        hit;

  // scan counters, pix_active also tells the pixel source when to drive
  vga_timing u_vga_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_active (pix_active),
    .pix_x      (pix_x),
    .frame_end  (frame_end),
    .hsync      (hsync),
    .vsync      (vsync),
    .blank_n    (blank_n)
  );

  target_finder u_target_finder (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_active (pix_active),
    .pix_r      (pix_r),
    .pix_g      (pix_g),
    .pix_b      (pix_b),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b),
    .hit        (hit)
  );

  // result lands one clock after frame end
  target_classifier u_target_classifier (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_active (pix_active),
    .pix_x      (pix_x),
    .hit        (hit),
    .frame_end  (frame_end),
    .direction  (direction),
    .detected   (detected),
    .frame_done (frame_done)
  );

  drive_fsm u_drive_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .ir_code     (ir_code),
    .ir_valid    (ir_valid),
    .speed       (speed),
    .direction   (direction),
    .detected    (detected),
    .frame_done  (frame_done),
    .motion      (motion),
    .motor_speed (motor_speed)
  );

endmodule

//--- verification/cam_tracker_properties.sv
// assertion checker on the tracker pixel path and drive outputs
`timescale 1ns/1ps

module cam_tracker_properties (
  input logic             clk,
  input logic             rst_n,
  input logic             pix_active,
  input logic [7:0]       pix_r,
  input logic [7:0]       pix_g,
  input logic [7:0]       pix_b,
  input logic [7:0]       ir_code,
  input logic             ir_valid,
  input logic [7:0]       vga_r,
  input logic [7:0]       vga_g,
  input logic [7:0]       vga_b,
  input logic             blank_n,
  input cam_pkg::motion_t motion,
  input logic [1:0]       motor_speed
);

  // failures seen so far, read by the testbench
  int   fail_cnt = 0;
  logic orange_in;

  // orange window on the incoming pixel
  assign orange_in = (pix_r >= cam_pkg::R_MIN) && (pix_g >= cam_pkg::G_MIN) &&
                     (pix_g <= cam_pkg::G_MAX) && (pix_b < cam_pkg::B_MAX);

  // orange pixel shows the marker one clock later
  a_marker: assert property (@(posedge clk) disable iff (!rst_n)
    pix_active && orange_in |=>
      (vga_r == cam_pkg::MARK_R) && (vga_g == cam_pkg::MARK_G) && (vga_b == cam_pkg::MARK_B))
    else begin
      $error("orange pixel was not replaced by the marker colour");
      fail_cnt++;
    end

  // any other active pixel passes through unchanged
  a_pass: assert property (@(posedge clk) disable iff (!rst_n)
    pix_active && !orange_in |=>
      (vga_r == $past(pix_r)) && (vga_g == $past(pix_g)) && (vga_b == $past(pix_b)))
    else begin
      $error("active pixel was not passed through after one clock");
      fail_cnt++;
    end

  a_black: assert property (@(posedge clk) disable iff (!rst_n)
    !blank_n |-> (vga_r == 8'd0) && (vga_g == 8'd0) && (vga_b == 8'd0))
    else begin
      $error("colour output not black while blanked");
      fail_cnt++;
    end

  // motors only get a speed while moving
  a_speed: assert property (@(posedge clk) disable iff (!rst_n)
    (motor_speed == 2'b00) == (motion == cam_pkg::MOT_HALT))
    else begin
      $error("motor speed and halt state disagree");
      fail_cnt++;
    end

  a_stop: assert property (@(posedge clk) disable iff (!rst_n)
    ir_valid && (ir_code == cam_pkg::CMD_STOP) |=> (motion == cam_pkg::MOT_HALT))
    else begin
      $error("stop command did not halt the motors");
      fail_cnt++;
    end

endmodule

bind cam_tracker_top cam_tracker_properties u_cam_tracker_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .pix_active  (pix_active),
  .pix_r       (pix_r),
  .pix_g       (pix_g),
  .pix_b       (pix_b),
  .ir_code     (ir_code),
  .ir_valid    (ir_valid),
  .vga_r       (vga_r),
  .vga_g       (vga_g),
  .vga_b       (vga_b),
  .blank_n     (blank_n),
  .motion      (motion),
  .motor_speed (motor_speed)
);

//--- verification/tb_cam_tracker.sv
// testbench for the camera tracker driving planned frames, remote commands and speed levels
`timescale 1ns/1ps

module tb_cam_tracker;

  localparam int ACT_PIX   = cam_pkg::H_ACTIVE * cam_pkg::V_ACTIVE;
  localparam int FRAME_CYC = cam_pkg::H_TOTAL * cam_pkg::V_TOTAL;
  localparam int RW        = cam_pkg::REGION_W;
  localparam int SLOTS     = cam_pkg::REGION_W * cam_pkg::V_ACTIVE;
  // first column of hsync and first line of vsync
  localparam int HS_START  = cam_pkg::H_ACTIVE + cam_pkg::H_FRONT;
  localparam int VS_START  = cam_pkg::V_ACTIVE + cam_pkg::V_FRONT;

  logic             clk;
  logic             rst_n;
  logic [7:0]       pix_r = 8'h00;
  logic [7:0]       pix_g = 8'h00;
  logic [7:0]       pix_b = 8'h00;
  logic [7:0]       ir_code;
  logic             ir_valid;
  logic [1:0]       speed;
  logic             pix_active;
  logic [7:0]       vga_r;
  logic [7:0]       vga_g;
  logic [7:0]       vga_b;
  logic             hsync;
  logic             vsync;
  logic             blank_n;
  cam_pkg::dir_t    direction;
  logic             detected;
  logic             frame_done;
  cam_pkg::motion_t motion;
  logic [1:0]       motor_speed;

  // orange positions of the current frame, row major over the active area
  bit                    orange_map [ACT_PIX];
  int                    pix_idx;
  int                    exp_cnt [3];
  cam_pkg::dir_t         exp_dir;
  cam_pkg::drive_state_t exp_state;
  cam_pkg::motion_t      exp_motion;
  int unsigned           seed;

  // reference scan position and the board levels it should produce
  int                    scan_h;
  int                    scan_v;
  logic                  exp_hsync;
  logic                  exp_vsync;
  logic                  exp_blank_n;

  cam_tracker_top u_cam_tracker_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_r       (pix_r),
    .pix_g       (pix_g),
    .pix_b       (pix_b),
    .ir_code     (ir_code),
    .ir_valid    (ir_valid),
    .speed       (speed),
    .pix_active  (pix_active),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .hsync       (hsync),
    .vsync       (vsync),
    .blank_n     (blank_n),
    .direction   (direction),
    .detected    (detected),
    .frame_done  (frame_done),
    .motion      (motion),
    .motor_speed (motor_speed)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_motion();
    check_eq("motion", 32'(motion), 32'(exp_motion));
    check_eq("motor_speed", 32'(motor_speed),
             (exp_motion == cam_pkg::MOT_HALT) ? 32'd0 : 32'(speed));
  endtask

  // orange stays inside the thresholds, filler always has too much blue
  task automatic drive_pixel(input bit orange);
    if (orange) begin
      pix_r = 8'(cam_pkg::R_MIN + $urandom % (256 - cam_pkg::R_MIN));
      pix_g = 8'(cam_pkg::G_MIN + $urandom % (cam_pkg::G_MAX - cam_pkg::G_MIN + 1));
      pix_b = 8'($urandom % cam_pkg::B_MAX);
    end else begin
      pix_r = 8'($urandom);
      pix_g = 8'($urandom);
      pix_b = 8'(cam_pkg::B_MAX + $urandom % (256 - cam_pkg::B_MAX));
    end
  endtask

  // count of active pixels already sampled in this frame
  always @(posedge clk) begin
    if (!rst_n) begin
      pix_idx <= 0;
    end else if (pix_active) begin
      pix_idx <= (pix_idx == ACT_PIX - 1) ? 0 : pix_idx + 1;
    end
  end

  // scan position from the frame geometry, syncs and blank one clock behind it
  always @(posedge clk) begin
    if (!rst_n) begin
      scan_h      <= 0;
      scan_v      <= 0;
      exp_hsync   <= 1'b1;
      exp_vsync   <= 1'b1;
      exp_blank_n <= 1'b0;
    end else begin
      exp_hsync   <= !((scan_h >= HS_START) && (scan_h < HS_START + cam_pkg::H_SYNC));
      exp_vsync   <= !((scan_v >= VS_START) && (scan_v < VS_START + cam_pkg::V_SYNC));
      exp_blank_n <= (scan_h < cam_pkg::H_ACTIVE) && (scan_v < cam_pkg::V_ACTIVE);
      if (scan_h == cam_pkg::H_TOTAL - 1) begin
        scan_h <= 0;
        scan_v <= (scan_v == cam_pkg::V_TOTAL - 1) ? 0 : scan_v + 1;
      end else begin
        scan_h <= scan_h + 1;
      end
    end
  end

  // active strobe, board levels and frame result pulse against the scan position
  always @(negedge clk) begin
    if (rst_n) begin
      check_eq("pix_active", 32'(pix_active),
               32'((scan_h < cam_pkg::H_ACTIVE) && (scan_v < cam_pkg::V_ACTIVE)));
      check_eq("hsync", 32'(hsync), 32'(exp_hsync));
      check_eq("vsync", 32'(vsync), 32'(exp_vsync));
      check_eq("blank_n", 32'(blank_n), 32'(exp_blank_n));
      check_eq("frame_done", 32'(frame_done), 32'((scan_v == VS_START) && (scan_h == 1)));
    end
  end

  always @(negedge clk) begin
    drive_pixel(pix_active && orange_map[pix_idx]);
  end

  // bound checker failures end the run here
  always @(negedge clk) begin
    if (u_cam_tracker_top.u_cam_tracker_properties.fail_cnt != 0) begin
      abort_run("a bound assertion on the tracker outputs failed");
    end
  end

  // region 3 means no target at all
  task automatic build_frame(input int region, input int hits);
    int pos;
    int col;
    foreach (orange_map[i]) orange_map[i] = 1'b0;
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
    if (region < 3) begin
      for (int n = 0; n < hits; n++) begin
        pos = int'($urandom % SLOTS);
        // step to the next free slot of the region
        while (orange_map[(pos / RW) * cam_pkg::H_ACTIVE + region * RW + pos % RW]) begin
          pos = (pos + 1) % SLOTS;
        end
        col = region * RW + pos % RW;
        orange_map[(pos / RW) * cam_pkg::H_ACTIVE + col] = 1'b1;
        exp_cnt[col / RW]++;
      end
    end
  endtask

  task automatic wait_frame_done(input bit check_idle);
    int cyc;
    cyc = 0;
    while (frame_done !== 1'b1) begin
      if (check_idle) begin
        check_eq("detected", 32'(detected), 32'd0);
        check_eq("motion", 32'(motion), 32'(cam_pkg::MOT_HALT));
      end
      if (cyc == 2 * FRAME_CYC) begin
        abort_run("Timeout: frame_done did not pulse within two frames");
      end
      cyc++;
      @(negedge clk);
    end
  endtask

  task automatic run_frame(input int region, input int hits, input bit check_idle);
    int total;
    bit det;
    build_frame(region, hits);
    wait_frame_done(check_idle);
    total = exp_cnt[0] + exp_cnt[1] + exp_cnt[2];
    det = (total >= cam_pkg::MIN_HITS);
    // centre wins ties, then left
    if (det) begin
      if ((exp_cnt[1] >= exp_cnt[0]) && (exp_cnt[1] >= exp_cnt[2])) begin
        exp_dir = cam_pkg::DIR_CENTER;
      end else if (exp_cnt[0] >= exp_cnt[2]) begin
        exp_dir = cam_pkg::DIR_LEFT;
      end else begin
        exp_dir = cam_pkg::DIR_RIGHT;
      end
    end
    check_eq("detected", 32'(detected), 32'(det));
    check_eq("direction", 32'(direction), 32'(exp_dir));
    // drive model reacts to the frame result
    if ((exp_state == cam_pkg::ST_SEARCH) && det) begin
      exp_state = cam_pkg::ST_TRACK;
    end else if (exp_state == cam_pkg::ST_TRACK) begin
      if (!det) begin
        exp_state  = cam_pkg::ST_SEARCH;
        exp_motion = cam_pkg::MOT_TURN_RIGHT;
      end else if (exp_dir == cam_pkg::DIR_LEFT) begin
        exp_motion = cam_pkg::MOT_TURN_LEFT;
      end else if (exp_dir == cam_pkg::DIR_RIGHT) begin
        exp_motion = cam_pkg::MOT_TURN_RIGHT;
      end else begin
        exp_motion = cam_pkg::MOT_FORWARD;
      end
    end
    @(negedge clk);
    check_motion();
  endtask

  task automatic apply_ir(input logic [7:0] code, input logic [1:0] spd);
    ir_code  = code;
    ir_valid = 1'b1;
    speed    = spd;
    case (code)
      cam_pkg::CMD_STOP: begin
        exp_state  = cam_pkg::ST_IDLE;
        exp_motion = cam_pkg::MOT_HALT;
      end
      cam_pkg::CMD_FWD: begin
        exp_state  = cam_pkg::ST_MANUAL;
        exp_motion = cam_pkg::MOT_FORWARD;
      end
      cam_pkg::CMD_LEFT: begin
        exp_state  = cam_pkg::ST_MANUAL;
        exp_motion = cam_pkg::MOT_TURN_LEFT;
      end
      cam_pkg::CMD_RIGHT: begin
        exp_state  = cam_pkg::ST_MANUAL;
        exp_motion = cam_pkg::MOT_TURN_RIGHT;
      end
      cam_pkg::CMD_AUTO: begin
        exp_state  = cam_pkg::ST_SEARCH;
        exp_motion = cam_pkg::MOT_TURN_RIGHT;
      end
      default: begin
        // other codes leave the model alone
      end
    endcase
    @(negedge clk);
    ir_valid = 1'b0;
    ir_code  = 8'h00;
    check_motion();
  endtask

  initial begin
    seed = 32'h7ff8;
    void'($urandom(seed));
    clk        = 1'b0;
    rst_n      = 1'b0;
    ir_code    = 8'h00;
    ir_valid   = 1'b0;
    speed      = 2'd1;
    exp_dir    = cam_pkg::DIR_CENTER;
    exp_state  = cam_pkg::ST_IDLE;
    exp_motion = cam_pkg::MOT_HALT;
    repeat (4) @(negedge clk);
    check_eq("blank_n", 32'(blank_n), 32'd0);
    check_eq("hsync", 32'(hsync), 32'd1);
    check_eq("vsync", 32'(vsync), 32'd1);
    check_eq("frame_done", 32'(frame_done), 32'd0);
    check_eq("direction", 32'(direction), 32'(cam_pkg::DIR_CENTER));
    check_motion();
    rst_n = 1'b1;
    // empty first frame, outputs stay idle until its result
    run_frame(3, 0, 1'b1);
    apply_ir(cam_pkg::CMD_FWD, 2'd2);
    apply_ir(cam_pkg::CMD_LEFT, 2'd3);
    apply_ir(cam_pkg::CMD_RIGHT, 2'd1);
    apply_ir(8'h55, 2'd1);
    // manual driving ignores the camera
    run_frame(0, 5, 1'b0);
    // three hits stay below the limit and keep the old direction
    run_frame(2, 3, 1'b0);
    apply_ir(cam_pkg::CMD_AUTO, 2'd2);
    run_frame(1, 6, 1'b0);
    run_frame(0, 4, 1'b0);
    run_frame(2, 7, 1'b0);
    run_frame(1, 4, 1'b0);
    // lost target falls back to the right spin
    run_frame(3, 0, 1'b0);
    run_frame(2, 5, 1'b0);
    run_frame(0, 8, 1'b0);
    apply_ir(cam_pkg::CMD_STOP, 2'd3);
    for (int k = 0; k < 4; k++) begin
      run_frame(int'($urandom % 4), int'($urandom % 12), 1'b0);
    end
    if (u_cam_tracker_top.u_cam_tracker_properties.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

endmodule

//--- tb.f
verilog/cam_pkg.sv
verilog/vga_timing.sv
verilog/target_finder.sv
verilog/target_classifier.sv
verilog/drive_fsm.sv
verilog/cam_tracker_top.sv
verification/cam_tracker_properties.sv
verification/tb_cam_tracker.sv

//--- Makefile
# Verilator build and run for the camera tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_tracker
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
